// ==== include/rename_config.svh ====
// Sizes are fixed at build time and each index width must be kept equal to log2 of its count
`ifndef RENAME_CONFIG_SVH
`define RENAME_CONFIG_SVH

////////////////////////////////////////////////////////////
// Register file sizes
////////////////////////////////////////////////////////////

// Architectural registers, x0 included
`define RC_NUM_AREGS 32
// Physical registers, p0 stays bound to x0
`define RC_NUM_PREGS 64

`define RC_AREG_W 5
`define RC_PREG_W 6

////////////////////////////////////////////////////////////
// Graduation list
////////////////////////////////////////////////////////////

// Power of two so the pointers wrap on their own
`define RC_GL_DEPTH 16
`define RC_GL_IDX_W 4

`endif

// ==== source/rename_pkg.sv ====
// Shared rename types; widths follow the config header and only ALU and load ops write rd
`default_nettype none

`include "rename_config.svh"

package rename_pkg;

    ////////////////////////////////////////////////////////////
    // Index types
    ////////////////////////////////////////////////////////////

    typedef logic [`RC_AREG_W-1:0]   areg_t;
    typedef logic [`RC_PREG_W-1:0]   preg_t;
    typedef logic [`RC_GL_IDX_W-1:0] gl_idx_t;

    ////////////////////////////////////////////////////////////
    // Enumerations
    ////////////////////////////////////////////////////////////

    // Instruction class as delivered by decode
    typedef enum logic [1:0] {
        OP_ALU    = 2'd0,
        OP_LOAD   = 2'd1,
        OP_STORE  = 2'd2,
        OP_BRANCH = 2'd3
    } opcode_e;

    // Life of one graduation list slot
    typedef enum logic [1:0] {
        GL_EMPTY   = 2'd0,
        GL_PENDING = 2'd1,
        GL_DONE    = 2'd2
    } gl_state_e;

    // Classes that produce a register result
    function automatic logic op_writes(input opcode_e op);
        logic writes;
        writes = (op == OP_ALU) || (op == OP_LOAD);
        return writes;
    endfunction

endpackage

`default_nettype wire

// ==== source/free_list.sv ====
// Holds at most NUM_PREGS-NUM_AREGS entries; pop on empty and push on full are not guarded
`timescale 1ns/1ps
`default_nettype none

`include "rename_config.svh"

module free_list import rename_pkg::*; (
    input  logic  clk_i,
    input  logic  rstn_i,
    input  logic  pop_i,
    input  logic  push_i,
    input  preg_t push_preg_i,
    output preg_t head_preg_o,
    output logic  empty_o
);

    // Only the registers above the architectural ones ever circulate
    localparam int FL_DEPTH = `RC_NUM_PREGS - `RC_NUM_AREGS;
    localparam int FL_PTR_W = $clog2(FL_DEPTH);

    preg_t               slots_q [FL_DEPTH];
    logic [FL_PTR_W-1:0] head_q;
    logic [FL_PTR_W-1:0] tail_q;
    logic [FL_PTR_W:0]   count_q;

    assign head_preg_o = slots_q[head_q];
    assign empty_o     = (count_q == '0);

    // Slots start filled with the upper half in ascending order
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < FL_DEPTH; i++) begin
                slots_q[i] <= preg_t'(`RC_NUM_AREGS + i);
            end
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= (FL_PTR_W+1)'(FL_DEPTH);
        end else begin
            if (push_i) begin
                slots_q[tail_q] <= push_preg_i;
                tail_q          <= tail_q + 1'b1;
            end
            if (pop_i) begin
                head_q <= head_q + 1'b1;
            end
            // Simultaneous pop and push leave the count alone
            case ({push_i, pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/rename_table.sv ====
// Speculative map only, there is no committed copy and no recovery; x0 is pinned to p0
`timescale 1ns/1ps
`default_nettype none

`include "rename_config.svh"

module rename_table import rename_pkg::*; (
    input  logic  clk_i,
    input  logic  rstn_i,
    input  areg_t rs1_i,
    input  areg_t rs2_i,
    input  areg_t rd_i,
    input  logic  write_i,
    input  preg_t new_preg_i,
    output preg_t prs1_o,
    output preg_t prs2_o,
    output preg_t old_prd_o
);

    preg_t map_q [`RC_NUM_AREGS];

    ////////////////////////////////////////////////////////////
    // Read ports
    ////////////////////////////////////////////////////////////

    // Reads see the map before this cycle's update
    assign prs1_o    = map_q[rs1_i];
    assign prs2_o    = map_q[rs2_i];
    assign old_prd_o = map_q[rd_i];

    ////////////////////////////////////////////////////////////
    // Destination update
    ////////////////////////////////////////////////////////////

    // Identity map out of reset
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < `RC_NUM_AREGS; i++) begin
                map_q[i] <= preg_t'(i);
            end
        end else if (write_i && (rd_i != '0)) begin
            map_q[rd_i] <= new_preg_i;
        end
    end

endmodule

`default_nettype wire

// ==== source/rename_stage.sv ====
// One instruction per cycle; ready ignores the opcode, so an empty free list also stalls stores
`timescale 1ns/1ps
`default_nettype none

`include "rename_config.svh"

module rename_stage import rename_pkg::*; (
    input  logic    clk_i,
    input  logic    rstn_i,
    input  logic    instr_valid_i,
    input  opcode_e instr_op_i,
    input  areg_t   instr_rs1_i,
    input  areg_t   instr_rs2_i,
    input  areg_t   instr_rd_i,
    input  logic    gl_full_i,
    input  gl_idx_t gl_tail_idx_i,
    input  logic    free_push_i,
    input  preg_t   free_preg_i,
    output logic    instr_ready_o,
    output logic    rename_valid_o,
    output preg_t   rename_prs1_o,
    output preg_t   rename_prs2_o,
    output preg_t   rename_prd_o,
    output preg_t   rename_old_prd_o,
    output gl_idx_t rename_gl_idx_o,
    output logic    gl_push_o,
    output areg_t   gl_rd_o,
    output preg_t   gl_prd_o,
    output preg_t   gl_old_prd_o,
    output logic    gl_writes_o
);

    logic  accept;
    logic  alloc;
    logic  free_empty;
    preg_t free_head;
    preg_t map_prs1;
    preg_t map_prs2;
    preg_t map_old_prd;

    logic  valid_q;
    areg_t rd_q;
    preg_t prs1_q;
    preg_t prs2_q;
    preg_t prd_q;
    preg_t old_prd_q;
    logic  writes_q;

    assign instr_ready_o = !free_empty && !gl_full_i;
    assign accept        = instr_valid_i && instr_ready_o;
    // Writes to x0 are dropped and take no register
    assign alloc         = accept && op_writes(instr_op_i) && (instr_rd_i != '0);

    free_list free_list_inst (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .pop_i       (alloc),
        .push_i      (free_push_i),
        .push_preg_i (free_preg_i),
        .head_preg_o (free_head),
        .empty_o     (free_empty)
    );

    rename_table rename_table_inst (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .rs1_i      (instr_rs1_i),
        .rs2_i      (instr_rs2_i),
        .rd_i       (instr_rd_i),
        .write_i    (alloc),
        .new_preg_i (free_head),
        .prs1_o     (map_prs1),
        .prs2_o     (map_prs2),
        .old_prd_o  (map_old_prd)
    );

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= accept;
        end
    end

    // Renamed record, only meaningful while valid_q is set
    always_ff @(posedge clk_i) begin
        if (accept) begin
            rd_q      <= instr_rd_i;
            prs1_q    <= map_prs1;
            prs2_q    <= map_prs2;
            prd_q     <= alloc ? free_head : '0;
            old_prd_q <= alloc ? map_old_prd : '0;
            writes_q  <= alloc;
        end
    end

    assign rename_valid_o   = valid_q;
    assign rename_prs1_o    = prs1_q;
    assign rename_prs2_o    = prs2_q;
    assign rename_prd_o     = prd_q;
    assign rename_old_prd_o = old_prd_q;
    // The entry lands at the current tail when it is pushed below
    assign rename_gl_idx_o  = gl_tail_idx_i;

    assign gl_push_o    = valid_q;
    assign gl_rd_o      = rd_q;
    assign gl_prd_o     = prd_q;
    assign gl_old_prd_o = old_prd_q;
    assign gl_writes_o  = writes_q;

endmodule

`default_nettype wire

// ==== source/graduation_list.sv ====
// Full counts the entry being pushed this cycle but not the one leaving; wb must hit a live entry
`timescale 1ns/1ps
`default_nettype none

`include "rename_config.svh"

module graduation_list import rename_pkg::*; (
    input  logic    clk_i,
    input  logic    rstn_i,
    input  logic    push_i,
    input  areg_t   push_rd_i,
    input  preg_t   push_prd_i,
    input  preg_t   push_old_prd_i,
    input  logic    push_writes_i,
    input  logic    wb_valid_i,
    input  gl_idx_t wb_gl_idx_i,
    input  logic    pop_i,
    output logic    full_o,
    output gl_idx_t tail_idx_o,
    output logic    head_done_o,
    output areg_t   head_rd_o,
    output preg_t   head_prd_o,
    output preg_t   head_old_prd_o,
    output logic    head_writes_o
);

    localparam logic [`RC_GL_IDX_W:0] GL_FULL_CNT = `RC_GL_DEPTH;
    localparam logic [`RC_GL_IDX_W:0] GL_LAST_CNT = `RC_GL_DEPTH - 1;

    gl_state_e              state_q   [`RC_GL_DEPTH];
    areg_t                  rd_q      [`RC_GL_DEPTH];
    preg_t                  prd_q     [`RC_GL_DEPTH];
    preg_t                  old_prd_q [`RC_GL_DEPTH];
    logic                   writes_q  [`RC_GL_DEPTH];
    gl_idx_t                head_q;
    gl_idx_t                tail_q;
    logic [`RC_GL_IDX_W:0]  count_q;

    // Rename sees full one cycle early since its record is still in flight
    assign full_o     = (count_q == GL_FULL_CNT) || (push_i && (count_q == GL_LAST_CNT));
    assign tail_idx_o = tail_q;

    assign head_done_o    = (state_q[head_q] == GL_DONE);
    assign head_rd_o      = rd_q[head_q];
    assign head_prd_o     = prd_q[head_q];
    assign head_old_prd_o = old_prd_q[head_q];
    assign head_writes_o  = writes_q[head_q];

    ////////////////////////////////////////////////////////////
    // Entry state and pointers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < `RC_GL_DEPTH; i++) begin
                state_q[i] <= GL_EMPTY;
            end
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (push_i) begin
                state_q[tail_q] <= GL_PENDING;
                tail_q          <= tail_q + 1'b1;
            end
            // Completion arrives in any order
            if (wb_valid_i) begin
                state_q[wb_gl_idx_i] <= GL_DONE;
            end
            if (pop_i) begin
                state_q[head_q] <= GL_EMPTY;
                head_q          <= head_q + 1'b1;
            end
            case ({push_i, pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Payload written in order at the tail
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            rd_q[tail_q]      <= push_rd_i;
            prd_q[tail_q]     <= push_prd_i;
            old_prd_q[tail_q] <= push_old_prd_i;
            writes_q[tail_q]  <= push_writes_i;
        end
    end

endmodule

`default_nettype wire

// ==== source/commit_stage.sv ====
// One retirement per cycle; the freed register returns at the edge that ends commit_valid_o
`timescale 1ns/1ps
`default_nettype none

`include "rename_config.svh"

module commit_stage import rename_pkg::*; (
    input  logic        clk_i,
    input  logic        rstn_i,
    input  logic        head_done_i,
    input  areg_t       head_rd_i,
    input  preg_t       head_prd_i,
    input  preg_t       head_old_prd_i,
    input  logic        head_writes_i,
    output logic        pop_o,
    output logic        free_push_o,
    output preg_t       free_preg_o,
    output logic        commit_valid_o,
    output areg_t       commit_rd_o,
    output preg_t       commit_prd_o,
    output preg_t       commit_old_prd_o,
    output logic        commit_freed_o,
    output logic [31:0] retired_count_o
);

    logic        valid_q;
    logic        freed_q;
    areg_t       rd_q;
    preg_t       prd_q;
    preg_t       old_prd_q;
    logic [31:0] retired_q;

    // A finished head leaves right away
    assign pop_o = head_done_i;

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            valid_q   <= 1'b0;
            freed_q   <= 1'b0;
            retired_q <= '0;
        end else begin
            valid_q <= head_done_i;
            freed_q <= head_done_i && head_writes_i;
            if (head_done_i) begin
                retired_q <= retired_q + 32'd1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (head_done_i) begin
            rd_q      <= head_rd_i;
            prd_q     <= head_prd_i;
            old_prd_q <= head_old_prd_i;
        end
    end

    assign commit_valid_o   = valid_q;
    assign commit_rd_o      = rd_q;
    assign commit_prd_o     = prd_q;
    assign commit_old_prd_o = old_prd_q;
    assign commit_freed_o   = freed_q;
    assign retired_count_o  = retired_q;

    // Old mapping is dead once its successor retires
    assign free_push_o = valid_q && freed_q;
    assign free_preg_o = old_prd_q;

endmodule

`default_nettype wire

// ==== source/rename_core.sv ====
// Writeback is a bare strobe and must only name entries already reported by rename
`timescale 1ns/1ps
`default_nettype none

`include "rename_config.svh"

module rename_core import rename_pkg::*; (
    input  logic        clk_i,
    input  logic        rstn_i,
    // Decoded instruction in
    input  logic        instr_valid_i,
    input  opcode_e     instr_op_i,
    input  areg_t       instr_rs1_i,
    input  areg_t       instr_rs2_i,
    input  areg_t       instr_rd_i,
    output logic        instr_ready_o,
    // Rename result
    output logic        rename_valid_o,
    output preg_t       rename_prs1_o,
    output preg_t       rename_prs2_o,
    output preg_t       rename_prd_o,
    output preg_t       rename_old_prd_o,
    output gl_idx_t     rename_gl_idx_o,
    // Writeback strobe
    input  logic        wb_valid_i,
    input  gl_idx_t     wb_gl_idx_i,
    // Retirement
    output logic        commit_valid_o,
    output areg_t       commit_rd_o,
    output preg_t       commit_prd_o,
    output preg_t       commit_old_prd_o,
    output logic        commit_freed_o,
    output logic [31:0] retired_count_o
);

    logic    gl_full;
    gl_idx_t gl_tail_idx;
    logic    gl_push;
    areg_t   gl_rd;
    preg_t   gl_prd;
    preg_t   gl_old_prd;
    logic    gl_writes;
    logic    gl_pop;
    logic    head_done;
    areg_t   head_rd;
    preg_t   head_prd;
    preg_t   head_old_prd;
    logic    head_writes;
    logic    free_push;
    preg_t   free_preg;

    ////////////////////////////////////////////////////////////
    // Rename
    ////////////////////////////////////////////////////////////

    rename_stage rename_stage_inst (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .instr_valid_i    (instr_valid_i),
        .instr_op_i       (instr_op_i),
        .instr_rs1_i      (instr_rs1_i),
        .instr_rs2_i      (instr_rs2_i),
        .instr_rd_i       (instr_rd_i),
        .gl_full_i        (gl_full),
        .gl_tail_idx_i    (gl_tail_idx),
        .free_push_i      (free_push),
        .free_preg_i      (free_preg),
        .instr_ready_o    (instr_ready_o),
        .rename_valid_o   (rename_valid_o),
        .rename_prs1_o    (rename_prs1_o),
        .rename_prs2_o    (rename_prs2_o),
        .rename_prd_o     (rename_prd_o),
        .rename_old_prd_o (rename_old_prd_o),
        .rename_gl_idx_o  (rename_gl_idx_o),
        .gl_push_o        (gl_push),
        .gl_rd_o          (gl_rd),
        .gl_prd_o         (gl_prd),
        .gl_old_prd_o     (gl_old_prd),
        .gl_writes_o      (gl_writes)
    );

    ////////////////////////////////////////////////////////////
    // Graduation list and commit
    ////////////////////////////////////////////////////////////

    graduation_list graduation_list_inst (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .push_i         (gl_push),
        .push_rd_i      (gl_rd),
        .push_prd_i     (gl_prd),
        .push_old_prd_i (gl_old_prd),
        .push_writes_i  (gl_writes),
        .wb_valid_i     (wb_valid_i),
        .wb_gl_idx_i    (wb_gl_idx_i),
        .pop_i          (gl_pop),
        .full_o         (gl_full),
        .tail_idx_o     (gl_tail_idx),
        .head_done_o    (head_done),
        .head_rd_o      (head_rd),
        .head_prd_o     (head_prd),
        .head_old_prd_o (head_old_prd),
        .head_writes_o  (head_writes)
    );

    commit_stage commit_stage_inst (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .head_done_i      (head_done),
        .head_rd_i        (head_rd),
        .head_prd_i       (head_prd),
        .head_old_prd_i   (head_old_prd),
        .head_writes_i    (head_writes),
        .pop_o            (gl_pop),
        .free_push_o      (free_push),
        .free_preg_o      (free_preg),
        .commit_valid_o   (commit_valid_o),
        .commit_rd_o      (commit_rd_o),
        .commit_prd_o     (commit_prd_o),
        .commit_old_prd_o (commit_old_prd_o),
        .commit_freed_o   (commit_freed_o),
        .retired_count_o  (retired_count_o)
    );

endmodule

`default_nettype wire

// ==== verification/rename_core_model.svh ====
// Reference model, include inside a module that imports rename_pkg after the config header
`ifndef RENAME_CORE_MODEL_SVH
`define RENAME_CORE_MODEL_SVH

// One graduation entry as it is expected to retire
typedef struct packed {
    areg_t   rd;
    preg_t   prd;
    preg_t   old_prd;
    logic    writes;
    gl_idx_t idx;
} gl_entry_t;

preg_t     map_model  [`RC_NUM_AREGS];
preg_t     free_model [$];
gl_entry_t gl_model   [$];
// Set once a writeback has been sent for a list slot
logic      wb_issued  [`RC_GL_DEPTH];
int        renamed_total;
int        retired_total;

task automatic init_reference();
    for (int i = 0; i < `RC_NUM_AREGS; i++) begin
        map_model[i] = preg_t'(i);
    end
    free_model.delete();
    for (int i = `RC_NUM_AREGS; i < `RC_NUM_PREGS; i++) begin
        free_model.push_back(preg_t'(i));
    end
    gl_model.delete();
    for (int i = 0; i < `RC_GL_DEPTH; i++) begin
        wb_issued[i] = 1'b0;
    end
    renamed_total = 0;
    retired_total = 0;
endtask

// Sources read the map before the destination update
task automatic predict_rename(
    input  opcode_e op,
    input  areg_t   rs1,
    input  areg_t   rs2,
    input  areg_t   rd,
    output preg_t   prs1,
    output preg_t   prs2,
    output preg_t   prd,
    output preg_t   old_prd,
    output gl_idx_t idx
);
    gl_entry_t entry;
    logic      allocates;
    allocates = ((op == OP_ALU) || (op == OP_LOAD)) && (rd != '0);
    prs1      = map_model[rs1];
    prs2      = map_model[rs2];
    prd       = '0;
    old_prd   = '0;
    if (allocates) begin
        prd           = free_model.pop_front();
        old_prd       = map_model[rd];
        map_model[rd] = prd;
    end
    // Slots are handed out in order, so the index is the rename count
    idx           = gl_idx_t'(renamed_total);
    renamed_total = renamed_total + 1;
    entry.rd      = rd;
    entry.prd     = prd;
    entry.old_prd = old_prd;
    entry.writes  = allocates;
    entry.idx     = idx;
    gl_model.push_back(entry);
endtask

task automatic predict_commit(output gl_entry_t entry);
    entry         = gl_model.pop_front();
    retired_total = retired_total + 1;
    if (entry.writes) begin
        free_model.push_back(entry.old_prd);
    end
endtask

`endif

// ==== verification/rename_core_tb.sv ====
// Random traffic from a fixed LFSR seed; stops at the first mismatch and needs a timing simulator
`timescale 1ns/1ps
`default_nettype none

`include "rename_config.svh"

module rename_core_tb import rename_pkg::*; ();

    localparam int STIM_CYCLES    = 2000;
    localparam int DRAIN_MARGIN   = 200;
    localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES + DRAIN_MARGIN;

    logic        clk_i;
    logic        rstn_i;
    logic        instr_valid_i;
    opcode_e     instr_op_i;
    areg_t       instr_rs1_i;
    areg_t       instr_rs2_i;
    areg_t       instr_rd_i;
    logic        instr_ready_o;
    logic        rename_valid_o;
    preg_t       rename_prs1_o;
    preg_t       rename_prs2_o;
    preg_t       rename_prd_o;
    preg_t       rename_old_prd_o;
    gl_idx_t     rename_gl_idx_o;
    logic        wb_valid_i;
    gl_idx_t     wb_gl_idx_i;
    logic        commit_valid_o;
    areg_t       commit_rd_o;
    preg_t       commit_prd_o;
    preg_t       commit_old_prd_o;
    logic        commit_freed_o;
    logic [31:0] retired_count_o;

    // Stimulus bookkeeping
    logic [31:0] lfsr_state;
    int          cycle_count = 0;
    logic        accept_pending;
    opcode_e     pend_op;
    areg_t       pend_rs1;
    areg_t       pend_rs2;
    areg_t       pend_rd;
    logic        exp_ready;
    logic        new_entry_valid;
    gl_idx_t     new_entry_idx;
    gl_idx_t     wb_pool [$];
    logic        ready_low_seen;

    `include "rename_core_model.svh"

    rename_core dut (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .instr_valid_i    (instr_valid_i),
        .instr_op_i       (instr_op_i),
        .instr_rs1_i      (instr_rs1_i),
        .instr_rs2_i      (instr_rs2_i),
        .instr_rd_i       (instr_rd_i),
        .instr_ready_o    (instr_ready_o),
        .rename_valid_o   (rename_valid_o),
        .rename_prs1_o    (rename_prs1_o),
        .rename_prs2_o    (rename_prs2_o),
        .rename_prd_o     (rename_prd_o),
        .rename_old_prd_o (rename_old_prd_o),
        .rename_gl_idx_o  (rename_gl_idx_o),
        .wb_valid_i       (wb_valid_i),
        .wb_gl_idx_i      (wb_gl_idx_i),
        .commit_valid_o   (commit_valid_o),
        .commit_rd_o      (commit_rd_o),
        .commit_prd_o     (commit_prd_o),
        .commit_old_prd_o (commit_old_prd_o),
        .commit_freed_o   (commit_freed_o),
        .retired_count_o  (retired_count_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    ////////////////////////////////////////////////////////////
    // Random bits and failure reporting
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h80200003;
        end
        return n;
    endfunction

    // One LFSR step per bit handed out
    function automatic logic [31:0] rand_bits(input int count);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v          = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    task automatic end_with_failure();
        $display("SOME TESTS FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_preg(input string name, input preg_t got, input preg_t exp);
        if (got !== exp) begin
            $display("FAIL time %0t: %s = %0d, expected %0d", $time, name, got, exp);
            end_with_failure();
        end
    endtask

    task automatic check_areg(input string name, input areg_t got, input areg_t exp);
        if (got !== exp) begin
            $display("FAIL time %0t: %s = %0d, expected %0d", $time, name, got, exp);
            end_with_failure();
        end
    endtask

    task automatic check_idx(input string name, input gl_idx_t got, input gl_idx_t exp);
        if (got !== exp) begin
            $display("FAIL time %0t: %s = %0d, expected %0d", $time, name, got, exp);
            end_with_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL time %0t: %s = %b, expected %b", $time, name, got, exp);
            end_with_failure();
        end
    endtask

    task automatic check_count(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL time %0t: %s = %0d, expected %0d", $time, name, got, exp);
            end_with_failure();
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Per-cycle checking and driving
    ////////////////////////////////////////////////////////////

    task automatic check_cycle();
        preg_t     exp_prs1;
        preg_t     exp_prs2;
        preg_t     exp_prd;
        preg_t     exp_old_prd;
        gl_idx_t   exp_idx;
        gl_entry_t done_entry;
        int        freed_now;
        int        free_count;
        freed_now = 0;
        check_flag("rename_valid_o", rename_valid_o, accept_pending);
        if (accept_pending) begin
            predict_rename(pend_op, pend_rs1, pend_rs2, pend_rd,
                           exp_prs1, exp_prs2, exp_prd, exp_old_prd, exp_idx);
            check_preg("rename_prs1_o", rename_prs1_o, exp_prs1);
            check_preg("rename_prs2_o", rename_prs2_o, exp_prs2);
            check_preg("rename_prd_o", rename_prd_o, exp_prd);
            check_preg("rename_old_prd_o", rename_old_prd_o, exp_old_prd);
            check_idx("rename_gl_idx_o", rename_gl_idx_o, exp_idx);
            new_entry_valid = 1'b1;
            new_entry_idx   = exp_idx;
        end
        if (commit_valid_o === 1'b1) begin
            if (gl_model.size() == 0) begin
                $display("Commit reported while no instruction was outstanding");
                end_with_failure();
            end
            predict_commit(done_entry);
            if (!wb_issued[done_entry.idx]) begin
                $display("List entry %0d retired before its writeback", done_entry.idx);
                end_with_failure();
            end
            wb_issued[done_entry.idx] = 1'b0;
            check_areg("commit_rd_o", commit_rd_o, done_entry.rd);
            check_preg("commit_prd_o", commit_prd_o, done_entry.prd);
            check_preg("commit_old_prd_o", commit_old_prd_o, done_entry.old_prd);
            check_flag("commit_freed_o", commit_freed_o, done_entry.writes);
            if (done_entry.writes) begin
                freed_now = 1;
            end
        end
        check_count("retired_count_o", retired_count_o, retired_total);
        // Freed register reaches the DUT free list one edge after commit
        free_count = free_model.size() - freed_now;
        exp_ready  = (free_count > 0) && (gl_model.size() < `RC_GL_DEPTH);
        check_flag("instr_ready_o", instr_ready_o, exp_ready);
        if (!exp_ready) begin
            ready_low_seen = 1'b1;
        end
    endtask

    task automatic drive_inputs(input logic issue_en, input logic wb_en);
        logic [1:0] op_bits;
        int         pick;
        instr_valid_i = 1'b0;
        if (issue_en) begin
            instr_valid_i = (rand_bits(3) != 0);
            op_bits       = 2'(rand_bits(2));
            instr_op_i    = opcode_e'(op_bits);
            instr_rs1_i   = areg_t'(rand_bits(5));
            instr_rs2_i   = areg_t'(rand_bits(5));
            instr_rd_i    = areg_t'(rand_bits(5));
        end
        // Taken at the next rising edge only if ready holds
        accept_pending = instr_valid_i && exp_ready;
        pend_op        = instr_op_i;
        pend_rs1       = instr_rs1_i;
        pend_rs2       = instr_rs2_i;
        pend_rd        = instr_rd_i;
        wb_valid_i     = 1'b0;
        if (wb_en && (wb_pool.size() > 0) && (rand_bits(2) != 0)) begin
            pick                   = rand_bits(4) % wb_pool.size();
            wb_gl_idx_i            = wb_pool[pick];
            wb_issued[wb_pool[pick]] = 1'b1;
            wb_pool.delete(pick);
            wb_valid_i             = 1'b1;
        end
        // Entry reported now is pushed at the next edge, so it waits a cycle
        if (new_entry_valid) begin
            wb_pool.push_back(new_entry_idx);
            new_entry_valid = 1'b0;
        end
    endtask

    // Writeback withheld so the list fills up
    function automatic logic in_hold_window(input int cycle);
        return ((cycle >= 100) && (cycle < 160)) || ((cycle >= 1200) && (cycle < 1260));
    endfunction

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        rstn_i          = 1'b0;
        instr_valid_i   = 1'b0;
        instr_op_i      = OP_ALU;
        instr_rs1_i     = '0;
        instr_rs2_i     = '0;
        instr_rd_i      = '0;
        wb_valid_i      = 1'b0;
        wb_gl_idx_i     = '0;
        lfsr_state      = 32'ha136369f;
        accept_pending  = 1'b0;
        pend_op         = OP_ALU;
        pend_rs1        = '0;
        pend_rs2        = '0;
        pend_rd         = '0;
        exp_ready       = 1'b1;
        new_entry_valid = 1'b0;
        new_entry_idx   = '0;
        ready_low_seen  = 1'b0;
        init_reference();
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        rstn_i = 1'b1;
        for (int cycle = 0; cycle < STIM_CYCLES; cycle++) begin
            @(negedge clk_i);
            check_cycle();
            drive_inputs(1'b1, !in_hold_window(cycle));
        end
        // Drain everything still in flight
        while ((gl_model.size() != 0) || accept_pending) begin
            @(negedge clk_i);
            check_cycle();
            drive_inputs(1'b0, 1'b1);
        end
        // A few idle cycles catch any late commit
        repeat (2) begin
            @(negedge clk_i);
            check_cycle();
            drive_inputs(1'b0, 1'b1);
        end
        if (ready_low_seen) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            $display("instr_ready_o never dropped during the writeback hold windows");
            end_with_failure();
        end
    end

    always @(posedge clk_i) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("Timeout, the run went past %0d cycles", TIMEOUT_CYCLES);
            end_with_failure();
        end
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+include
+incdir+verification
source/rename_pkg.sv
source/free_list.sv
source/rename_table.sv
source/rename_stage.sv
source/graduation_list.sv
source/commit_stage.sv
source/rename_core.sv
verification/rename_core_tb.sv

// ==== Makefile ====
# Verilator flow for the rename core

TOP := rename_core_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -j 0 -f files.f --top-module $(TOP) -Mdir obj_dir

# Pass only when the simulation reports success
run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

lint:
	verilator --lint-only -Wall --timing -f files.f --top-module rename_core

clean:
	rm -rf obj_dir
